// ==== hdl/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

	localparam int ADDR_W   = 32;
	localparam int LINE_W   = 128;
	localparam int INST_W   = 32;
	localparam int NUM_WAYS = 4;
	localparam int OFFSET_W = 4;

	// Selects one of the four instruction words in a line
	localparam int WORD_SEL_W = OFFSET_W - 2;

	typedef logic [LINE_W-1:0] line_t;
	typedef logic [NUM_WAYS-1:0] way_vec_t;

	function automatic logic [WORD_SEL_W-1:0] word_offset(input logic [ADDR_W-1:0] a);
		return a[OFFSET_W-1:2];
	endfunction

	function automatic logic [INST_W-1:0] line_word(input line_t l,
			input logic [WORD_SEL_W-1:0] sel);
		return l[sel*INST_W +: INST_W];
	endfunction

endpackage

`default_nettype wire

// ==== hdl/line_array_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface line_array_if #(
	parameter int NUM_SETS = 64
);
	import icache_pkg::*;

	localparam int IDX_W = $clog2(NUM_SETS);

	logic en;
	logic we;
	logic [IDX_W-1:0] idx;
	line_t wdata;
	line_t rdata;

	modport ctrl (
		output en, we, idx, wdata,
		input rdata
	);

	modport array (
		input en, we, idx, wdata,
		output rdata
	);

endinterface

`default_nettype wire

// ==== hdl/icache_data_way.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_data_way #(
	parameter int NUM_SETS = 64
) (
	input logic clk,
	line_array_if.array arr
);
	import icache_pkg::*;

	line_t mem [NUM_SETS];
	line_t rd_q;

	// A write also returns the line written, and the read port keeps its
	// last line while the way is idle
	always_ff @(posedge clk) begin
		if (arr.en) begin
			if (arr.we) begin
				mem[arr.idx] <= arr.wdata;
				rd_q <= arr.wdata;
			end else begin
				rd_q <= mem[arr.idx];
			end
		end
	end

	assign arr.rdata = rd_q;

endmodule

`default_nettype wire

// ==== hdl/icache_tag_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_tag_array #(
	parameter int NUM_SETS = 64
) (
	input logic clk,
	input logic rst,
	input logic [icache_pkg::ADDR_W-1:0] addr,
	input logic lookup,
	input logic fill,
	output icache_pkg::way_vec_t hit_way,
	output icache_pkg::way_vec_t victim
);
	import icache_pkg::*;

	localparam int IDX_W = $clog2(NUM_SETS);
	localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W;

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;

	logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
	logic [TAG_W-1:0] tags [NUM_WAYS][NUM_SETS];
	way_vec_t set_vld;
	way_vec_t ptr_q;

	assign idx = addr[OFFSET_W +: IDX_W];
	assign tag = addr[ADDR_W-1 -: TAG_W];
	assign set_vld = valid_q[idx];

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_way[w] = set_vld[w] && (tags[w][idx] == tag);
		end
	end

	// The lowest empty way is taken before the pointer way
	always_comb begin
		victim = ptr_q;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (!set_vld[w]) begin
				victim = way_vec_t'(1) << w;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ptr_q <= way_vec_t'(1);
		end else if (lookup) begin
			ptr_q <= {ptr_q[NUM_WAYS-2:0], ptr_q[NUM_WAYS-1]};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (fill) begin
			valid_q[idx] <= set_vld | victim;
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (victim[w]) begin
					tags[w][idx] <= tag;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/icache.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache #(
	parameter int NUM_SETS = 64
) (
	input logic clk,
	input logic rst,
	input logic [icache_pkg::ADDR_W-1:0] addr,
	input logic valid,
	input logic flush,
	input logic downstream_ready,
	input icache_pkg::line_t refill_line,
	output logic [icache_pkg::INST_W-1:0] inst,
	output logic inst_valid,
	output logic hit,
	line_array_if.ctrl way [icache_pkg::NUM_WAYS]
);
	import icache_pkg::*;

	localparam int IDX_W = $clog2(NUM_SETS);

	logic accept;
	logic lookup;
	logic miss;
	logic fill;
	way_vec_t hit_way;
	way_vec_t victim;

	way_vec_t hit_q;
	line_t refill_q;
	logic [WORD_SEL_W-1:0] off_q;
	logic hit_flag_q;
	logic inst_valid_q;

	line_t rd_line [NUM_WAYS];
	line_t sel_line;

	assign accept = valid && downstream_ready;
	assign lookup = downstream_ready && !flush;
	assign miss = (hit_way == '0);

	// A flushed miss still fills, so a repeat of the address hits
	assign fill = accept && miss;

	icache_tag_array #(
		.NUM_SETS(NUM_SETS)
	) u_tags (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.lookup(lookup),
		.fill(fill),
		.hit_way(hit_way),
		.victim(victim)
	);

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		assign way[w].en = accept && (hit_way[w] || (miss && victim[w]));
		assign way[w].we = miss;
		assign way[w].idx = addr[OFFSET_W +: IDX_W];
		assign way[w].wdata = refill_line;
		assign rd_line[w] = way[w].rdata;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hit_q <= '0;
			hit_flag_q <= 1'b0;
			inst_valid_q <= 1'b0;
		end else if (downstream_ready) begin
			hit_q <= valid ? hit_way : '0;
			hit_flag_q <= valid && !miss;
			inst_valid_q <= valid && !flush;
		end
	end

	always_ff @(posedge clk) begin
		if (downstream_ready) begin
			refill_q <= refill_line;
			off_q <= word_offset(addr);
		end
	end

	// On a hit the way's read port carries the line, on a miss the
	// forwarded refill line is used instead
	always_comb begin
		sel_line = refill_q;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (hit_q[w]) begin
				sel_line = rd_line[w];
			end
		end
	end

	assign inst = line_word(sel_line, off_q);
	assign inst_valid = inst_valid_q;
	assign hit = hit_flag_q;

endmodule

`default_nettype wire

// ==== hdl/inst_backing_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_backing_mem #(
	parameter int MEM_LINES = 256
) (
	input logic clk,
	input logic [icache_pkg::ADDR_W-1:0] addr,
	input logic load_en,
	input logic [icache_pkg::ADDR_W-1:0] load_addr,
	input logic [icache_pkg::INST_W-1:0] load_data,
	output icache_pkg::line_t line
);
	import icache_pkg::*;

	localparam int LIDX_W = $clog2(MEM_LINES);

	line_t mem [MEM_LINES];

	logic [LIDX_W-1:0] rd_idx;
	logic [LIDX_W-1:0] ld_idx;
	logic [WORD_SEL_W-1:0] ld_word;

	// Upper address bits are dropped, so the program image repeats
	assign rd_idx = addr[OFFSET_W +: LIDX_W];
	assign ld_idx = load_addr[OFFSET_W +: LIDX_W];
	assign ld_word = word_offset(load_addr);

	assign line = mem[rd_idx];

	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[ld_idx][ld_word*INST_W +: INST_W] <= load_data;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fetch_subsystem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_subsystem_top #(
	parameter int NUM_SETS = 64,
	parameter int MEM_LINES = 256
) (
	input logic clk,
	input logic rst,
	input logic [icache_pkg::ADDR_W-1:0] addr,
	input logic valid,
	input logic flush,
	input logic downstream_ready,
	input logic load_en,
	input logic [icache_pkg::ADDR_W-1:0] load_addr,
	input logic [icache_pkg::INST_W-1:0] load_data,
	output logic [icache_pkg::INST_W-1:0] inst,
	output logic inst_valid,
	output logic hit
);
	import icache_pkg::*;

	line_t refill_line;

	line_array_if #(.NUM_SETS(NUM_SETS)) way_if [NUM_WAYS] ();

	inst_backing_mem #(
		.MEM_LINES(MEM_LINES)
	) u_mem (
		.clk(clk),
		.addr(addr),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.line(refill_line)
	);

	icache #(
		.NUM_SETS(NUM_SETS)
	) u_icache (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.valid(valid),
		.flush(flush),
		.downstream_ready(downstream_ready),
		.refill_line(refill_line),
		.inst(inst),
		.inst_valid(inst_valid),
		.hit(hit),
		.way(way_if)
	);

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_data
		icache_data_way #(
			.NUM_SETS(NUM_SETS)
		) u_way (
			.clk(clk),
			.arr(way_if[w])
		);
	end

endmodule

`default_nettype wire

// ==== sim/icache_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_assertions (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic downstream_ready,
	input icache_pkg::way_vec_t hit_way,
	input logic [icache_pkg::INST_W-1:0] inst,
	input logic inst_valid,
	input logic hit
);

	// A tag is never resident in two ways of the same set
	a_single_hit_way: assert property (@(posedge clk) disable iff (rst)
		$onehot0(hit_way))
		else $error("more than one way hits the same address");

	// Only a flushed request may raise hit while inst_valid stays low
	a_hit_needs_valid: assert property (@(posedge clk) disable iff (rst)
		$rose(hit) && !inst_valid |-> $past(flush))
		else $error("hit rose without inst_valid on an unflushed request");

	a_stall_holds: assert property (@(posedge clk) disable iff (rst)
		!downstream_ready |=> $stable(inst) && $stable(inst_valid) && $stable(hit))
		else $error("outputs changed across a stalled cycle");

	a_reset_clears_valid: assert property (@(posedge clk)
		rst |=> !inst_valid)
		else $error("inst_valid high in the cycle after reset");

endmodule

bind icache icache_assertions u_assertions (
	.clk(clk),
	.rst(rst),
	.flush(flush),
	.downstream_ready(downstream_ready),
	.hit_way(hit_way),
	.inst(inst),
	.inst_valid(inst_valid),
	.hit(hit)
);

`default_nettype wire

// ==== sim/icache_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_tb;

	localparam int NUM_SETS = 64;
	localparam int MEM_LINES = 256;
	localparam int MEM_WORDS = MEM_LINES * 4;
	localparam int TAG_SHIFT = 4 + $clog2(NUM_SETS);

	typedef struct packed {
		logic [31:0] addr;
		logic valid;
		logic flush;
		logic [3:0] stall;
		logic exp_hit;
	} entry_t;

	logic clk;
	logic rst;
	logic [31:0] addr;
	logic valid;
	logic flush;
	logic downstream_ready;
	logic load_en;
	logic [31:0] load_addr;
	logic [31:0] load_data;
	logic [31:0] inst;
	logic inst_valid;
	logic hit;

	logic [31:0] mem_copy [MEM_WORDS];
	entry_t stim_q [$];
	logic [31:0] seen_tags [NUM_SETS][4];
	int seen_cnt [NUM_SETS];
	integer seed;
	int cycles;
	int cycle_limit;

	fetch_subsystem_top #(
		.NUM_SETS(NUM_SETS),
		.MEM_LINES(MEM_LINES)
	) uut (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.valid(valid),
		.flush(flush),
		.downstream_ready(downstream_ready),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.inst(inst),
		.inst_valid(inst_valid),
		.hit(hit)
	);

	always #20 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("Mismatch at %0t ns: %s = 0x%h, expected 0x%h",
				$time, name, actual, expected));
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			abort_run("Timeout: the test did not finish within the cycle limit");
		end
	end

	function automatic int word_index(input logic [31:0] a);
		return (a >> 2) % MEM_WORDS;
	endfunction

	// A line counts as cached once its tag has been seen in its set
	function automatic logic is_resident(input logic [31:0] a);
		int s;
		s = (a >> 4) % NUM_SETS;
		for (int i = 0; i < seen_cnt[s]; i++) begin
			if (seen_tags[s][i] == (a >> TAG_SHIFT)) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic record_access(input logic [31:0] a);
		int s;
		s = (a >> 4) % NUM_SETS;
		if (!is_resident(a)) begin
			if (seen_cnt[s] == 4) begin
				abort_run("The stimulus table uses more than four tags in one set");
			end
			seen_tags[s][seen_cnt[s]] = a >> TAG_SHIFT;
			seen_cnt[s] = seen_cnt[s] + 1;
		end
	endtask

	task automatic add_entry(input logic [31:0] a, input logic v, input logic f,
			input int st, input logic h);
		stim_q.push_back(entry_t'({a, v, f, st[3:0], h}));
	endtask

	task automatic build_table();
		// Four lines are touched once at different word offsets and then read again
		add_entry(32'h0000_0100, 1, 0, 0, 0);
		add_entry(32'h0000_0214, 1, 0, 0, 0);
		add_entry(32'h0000_0328, 1, 0, 0, 0);
		add_entry(32'h0000_043c, 1, 0, 0, 0);
		add_entry(32'h0000_0104, 1, 0, 0, 1);
		add_entry(32'h0000_0108, 1, 0, 0, 1);
		add_entry(32'h0000_010c, 1, 0, 0, 1);
		add_entry(32'h0000_0100, 1, 0, 0, 1);
		add_entry(32'h0000_0210, 1, 0, 0, 1);
		add_entry(32'h0000_0320, 1, 0, 0, 1);
		add_entry(32'h0000_0430, 1, 0, 0, 1);
		// Set 5 filled with four tags
		add_entry(32'h0000_0050, 1, 0, 0, 0);
		add_entry(32'h0000_0450, 1, 0, 0, 0);
		add_entry(32'h0000_0850, 1, 0, 0, 0);
		add_entry(32'h0000_0c50, 1, 0, 0, 0);
		add_entry(32'h0000_0454, 1, 0, 0, 1);
		add_entry(32'h0000_0058, 1, 0, 0, 1);
		add_entry(32'h0000_0c5c, 1, 0, 0, 1);
		add_entry(32'h0000_0850, 1, 0, 0, 1);
		add_entry(32'h0000_0054, 1, 0, 0, 1);
		// Set 16 gets three more tags next to 0x100
		add_entry(32'h0000_0500, 1, 0, 0, 0);
		add_entry(32'h0000_0904, 1, 0, 0, 0);
		add_entry(32'h0000_0d08, 1, 0, 0, 0);
		add_entry(32'h0000_010c, 1, 0, 0, 1);
		add_entry(32'h0000_0d00, 1, 0, 0, 1);
		add_entry(32'h0000_050c, 1, 0, 0, 1);
		// A flushed miss still fills and a flushed hit reports only hit
		add_entry(32'h0000_0600, 1, 1, 0, 0);
		add_entry(32'h0000_0604, 1, 0, 0, 1);
		add_entry(32'h0000_0608, 1, 1, 0, 1);
		add_entry(32'h0000_060c, 1, 0, 0, 1);
		add_entry(32'h0000_0700, 1, 0, 3, 0);
		add_entry(32'h0000_0704, 1, 0, 2, 1);
		add_entry(32'h0000_0058, 1, 0, 1, 1);
		add_entry(32'h0000_07a0, 1, 1, 2, 0);
		add_entry(32'h0000_07a4, 1, 0, 0, 1);
		// Idle cycles leave the line uncached
		add_entry(32'h0000_0a00, 0, 0, 0, 0);
		add_entry(32'h0000_0a00, 0, 0, 1, 0);
		add_entry(32'h0000_0a00, 1, 0, 0, 0);
		add_entry(32'h0000_0a08, 1, 0, 0, 1);
		add_entry(32'h0000_0e00, 0, 1, 0, 0);
		add_entry(32'h0000_0100, 1, 0, 0, 1);
	endtask

	task automatic load_program();
		logic [31:0] word;
		for (int i = 0; i < MEM_WORDS; i++) begin
			word = $random(seed);
			mem_copy[i] = word;
			load_en = 1'b1;
			load_addr = i * 4;
			load_data = word;
			@(negedge clk);
			check_value("inst_valid", inst_valid, 0);
			check_value("hit", hit, 0);
		end
		load_en = 1'b0;
	endtask

	task automatic apply_entry(input entry_t e);
		logic [31:0] held_inst;
		logic held_inst_valid;
		logic held_hit;
		logic exp_hit;
		held_inst = inst;
		held_inst_valid = inst_valid;
		held_hit = hit;
		exp_hit = e.valid && is_resident(e.addr);
		check_value("table hit flag", e.exp_hit, exp_hit);
		addr = e.addr;
		valid = e.valid;
		flush = e.flush;
		downstream_ready = (e.stall == 0);
		for (int s = 0; s < e.stall; s++) begin
			@(negedge clk);
			check_value("inst during stall", inst, held_inst);
			check_value("inst_valid during stall", inst_valid, held_inst_valid);
			check_value("hit during stall", hit, held_hit);
		end
		downstream_ready = 1'b1;
		@(negedge clk);
		check_value("inst_valid", inst_valid, e.valid && !e.flush);
		check_value("hit", hit, exp_hit);
		if (e.valid) begin
			check_value("inst", inst, mem_copy[word_index(e.addr)]);
			record_access(e.addr);
		end
	endtask

	initial begin
		seed = 32'habc2;
		clk = 1'b0;
		rst = 1'b1;
		addr = '0;
		valid = 1'b0;
		flush = 1'b0;
		downstream_ready = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		cycles = 0;
		for (int s = 0; s < NUM_SETS; s++) begin
			seen_cnt[s] = 0;
		end
		build_table();
		cycle_limit = 2 * stim_q.size() + MEM_WORDS + 64;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		load_program();
		foreach (stim_q[i]) begin
			apply_entry(stim_q[i]);
		end
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/icache_pkg.sv
hdl/line_array_if.sv
hdl/icache_data_way.sv
hdl/icache_tag_array.sv
hdl/icache.sv
hdl/inst_backing_mem.sv
hdl/fetch_subsystem_top.sv
sim/icache_assertions.sv
sim/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache_fetch

sources:
  - files:
      - hdl/icache_pkg.sv
      - hdl/line_array_if.sv
      - hdl/icache_data_way.sv
      - hdl/icache_tag_array.sv
      - hdl/icache.sv
      - hdl/inst_backing_mem.sv
      - hdl/fetch_subsystem_top.sv
  - target: simulation
    files:
      - sim/icache_assertions.sv
      - sim/icache_tb.sv
